// File: all.f
+incdir+rtl
rtl/shift_unit_pkg.sv
rtl/shift_issue.sv
rtl/barrel_shifter.sv
rtl/cond_eval.sv
rtl/lane_merge_flags.sv
rtl/result_return.sv
rtl/shift_unit_top.sv
verification/shift_unit_checker.sv
verification/shift_unit_tb.sv

// File: rtl/barrel_shifter.sv
`timescale 1ns/1ps
`include "shift_unit_config.svh"

module barrel_shifter
  import shift_unit_pkg::*;
(
  input  shift_op_e             op,
  input  logic                  wide,
  input  ctrl_word_u            ctrl,
  input  logic [`SU_DATA_W-1:0] a,
  output logic [`SU_DATA_W-1:0] shifted,
  output logic                  carry
);

  shift_op_e            eff_op;
  logic [`SU_AMT_W-1:0] amt;
  logic [64:0]          l64;
  logic [64:0]          r64;
  logic signed [64:0]   s64;
  logic [32:0]          l32;
  logic [32:0]          r32;
  logic signed [32:0]   s32;

  // dir_force turns any code into a logical right shift.
  assign eff_op = ctrl.shift.dir_force ? op_shr : op;

  // 32-bit mode shifts by amount modulo 32.
  assign amt = wide ? ctrl.shift.amount : {1'b0, ctrl.shift.amount[`SU_AMT_W-2:0]};

  // one extra bit catches the last bit shifted out.
  always_comb begin
    l64 = {1'b0, a} << amt;
    r64 = {a, 1'b0} >> amt;
    s64 = $signed({a, 1'b0}) >>> amt;
    l32 = {1'b0, a[31:0]} << amt;
    r32 = {a[31:0], 1'b0} >> amt;
    s32 = $signed({a[31:0], 1'b0}) >>> amt;
  end

  always_comb begin
    if (wide) begin
      case (eff_op)
        op_shr:  {shifted, carry} = r64;
        op_sar:  {shifted, carry} = s64;
        default: {carry, shifted} = l64;
      endcase
    end else begin
      shifted[63:32] = 32'b0;
      case (eff_op)
        op_shr:  {shifted[31:0], carry} = r32;
        op_sar:  {shifted[31:0], carry} = s32;
        default: {carry, shifted[31:0]} = l32;
      endcase
    end
  end

endmodule

// File: rtl/cond_eval.sv
`timescale 1ns/1ps
`include "shift_unit_config.svh"

module cond_eval
  import shift_unit_pkg::*;
(
  input  logic [`SU_COND_W-1:0] cond,
  input  logic [`SU_FLAG_W-1:0] flags,
  output logic                  take
);

  logic cond_en;
  logic hit;

  assign cond_en = cond[`SU_COND_W-1];

  // codes 8 to 15 never pass.
  always_comb begin
    case (cond[`SU_COND_W-2:0])
      4'd0:    hit = 1'b1;
      4'd1:    hit = flags[flag_z];
      4'd2:    hit = !flags[flag_z];
      4'd3:    hit = flags[flag_c];
      4'd4:    hit = !flags[flag_c];
      4'd5:    hit = flags[flag_s];
      4'd6:    hit = !flags[flag_s];
      4'd7:    hit = flags[flag_p];
      default: hit = 1'b0;
    endcase
  end

  // unconditional unless the enable bit is set.
  assign take = cond_en ? hit : 1'b1;

endmodule

// File: rtl/lane_merge_flags.sv
`timescale 1ns/1ps
`include "shift_unit_config.svh"

module lane_merge_flags
  import shift_unit_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  iss_valid,
  input  shift_op_e             iss_op,
  input  logic                  iss_wide,
  input  logic [`SU_COND_W-1:0] iss_cond,
  input  logic [`SU_FLAG_W-1:0] iss_flags,
  input  logic [`SU_DATA_W-1:0] iss_a,
  input  ctrl_word_u            iss_ctrl,
  output logic                  stage_ready,
  output logic                  stg_valid,
  output logic [`SU_DATA_W-1:0] stg_result,
  output logic [`SU_FLAG_W-1:0] stg_flags,
  output logic                  stg_skipped,
  input  logic                  ret_ready
);

  logic [`SU_DATA_W-1:0] shifted;
  logic                  carry;
  logic                  take;
  logic [`SU_DATA_W-1:0] merged;
  logic [`SU_DATA_W-1:0] nxt_result;
  logic [`SU_FLAG_W-1:0] nxt_flags;

  barrel_shifter barrel_shifter_i (
    .op      (iss_op),
    .wide    (iss_wide),
    .ctrl    (iss_ctrl),
    .a       (iss_a),
    .shifted (shifted),
    .carry   (carry)
  );

  cond_eval cond_eval_i (
    .cond  (iss_cond),
    .flags (iss_flags),
    .take  (take)
  );

  // masked-off lanes keep the old operand byte.
  always_comb begin
    for (int i = 0; i < `SU_LANES; i++) begin
      if (iss_ctrl.merge.merge_en && !iss_ctrl.merge.lane_mask[i])
        merged[i*8 +: 8] = iss_a[i*8 +: 8];
      else
        merged[i*8 +: 8] = shifted[i*8 +: 8];
    end
    nxt_result = merged;
    if (!iss_wide)
      nxt_result[63:32] = iss_ctrl.shift.sign_fill ? {32{merged[31]}} : 32'b0;
    nxt_flags[flag_c] = carry;
    nxt_flags[flag_o] = 1'b0;
    nxt_flags[flag_a] = 1'b0;
    nxt_flags[flag_s] = iss_wide ? nxt_result[63] : nxt_result[31];
    nxt_flags[flag_z] = iss_wide ? (nxt_result == '0) : (nxt_result[31:0] == 32'b0);
    nxt_flags[flag_p] = ~^nxt_result[7:0];
  end

  assign stage_ready = !stg_valid || ret_ready;

  always_ff @(posedge clk) begin
    if (reset)
      stg_valid <= 1'b0;
    else if (iss_valid && stage_ready)
      stg_valid <= 1'b1;
    else if (ret_ready)
      stg_valid <= 1'b0;
  end

  // a skipped op passes operand and flags through.
  always_ff @(posedge clk) begin
    if (iss_valid && stage_ready) begin
      stg_result  <= take ? nxt_result : iss_a;
      stg_flags   <= take ? nxt_flags : iss_flags;
      stg_skipped <= !take;
    end
  end

  a_stage_hold: assert property (@(posedge clk) disable iff (reset)
    stg_valid && !ret_ready |=> stg_valid && $stable(stg_result))
    else $error("stg_result changed while stalled");

endmodule

// File: rtl/result_return.sv
`timescale 1ns/1ps
`include "shift_unit_config.svh"

module result_return (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  stg_valid,
  input  logic [`SU_DATA_W-1:0] stg_result,
  input  logic [`SU_FLAG_W-1:0] stg_flags,
  input  logic                  stg_skipped,
  output logic                  ret_ready,
  output logic                  out_req,
  output logic [`SU_DATA_W-1:0] out_result,
  output logic [`SU_FLAG_W-1:0] out_flags,
  output logic                  out_skipped,
  input  logic                  out_ack
);

  logic load;

  // free once the last return has fully closed.
  assign ret_ready = !out_req && !out_ack;
  assign load      = stg_valid && ret_ready;

  always_ff @(posedge clk) begin
    if (reset)
      out_req <= 1'b0;
    else if (load)
      out_req <= 1'b1;
    else if (out_req && out_ack)
      out_req <= 1'b0;
  end

  // result holder, stable for the whole request phase.
  always_ff @(posedge clk) begin
    if (load) begin
      out_result  <= stg_result;
      out_flags   <= stg_flags;
      out_skipped <= stg_skipped;
    end
  end

  a_out_hold: assert property (@(posedge clk) disable iff (reset)
    out_req && !out_ack |=> out_req && $stable(out_result))
    else $error("out_result changed during request");

endmodule

// File: rtl/shift_issue.sv
`timescale 1ns/1ps
`include "shift_unit_config.svh"

module shift_issue
  import shift_unit_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_req,
  input  shift_op_e             in_op,
  input  logic                  in_wide,
  input  logic [`SU_COND_W-1:0] in_cond,
  input  logic [`SU_FLAG_W-1:0] in_flags,
  input  logic [`SU_DATA_W-1:0] in_a,
  input  ctrl_word_u            in_ctrl,
  output logic                  in_ack,
  input  logic                  stage_ready,
  output logic                  iss_valid,
  output shift_op_e             iss_op,
  output logic                  iss_wide,
  output logic [`SU_COND_W-1:0] iss_cond,
  output logic [`SU_FLAG_W-1:0] iss_flags,
  output logic [`SU_DATA_W-1:0] iss_a,
  output ctrl_word_u            iss_ctrl
);

  logic capture;
  logic taken;

  // accept only with an empty holder and the last handshake closed.
  assign capture = in_req && !iss_valid && !in_ack;
  assign taken   = iss_valid && stage_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      in_ack    <= 1'b0;
      iss_valid <= 1'b0;
    end else begin
      if (capture)
        in_ack <= 1'b1;
      else if (in_ack && !in_req)
        in_ack <= 1'b0;
      if (capture)
        iss_valid <= 1'b1;
      else if (taken)
        iss_valid <= 1'b0;
    end
  end

  // holding register.
  always_ff @(posedge clk) begin
    if (capture) begin
      iss_op    <= in_op;
      iss_wide  <= in_wide;
      iss_cond  <= in_cond;
      iss_flags <= in_flags;
      iss_a     <= in_a;
      iss_ctrl  <= in_ctrl;
    end
  end

  // ack must hold until the producer withdraws its request.
  a_ack_hold: assert property (@(posedge clk) disable iff (reset)
    in_ack && in_req |=> in_ack)
    else $error("in_ack fell while in_req was high");

endmodule

// File: rtl/shift_unit_config.svh
`ifndef SHIFT_UNIT_CONFIG_SVH
`define SHIFT_UNIT_CONFIG_SVH

// operand width, one word.
`define SU_DATA_W 64

// shift amount width.
`define SU_AMT_W 6

// number of COASZP flags.
`define SU_FLAG_W 6

// condition field, top bit enables, low four bits are the code.
`define SU_COND_W 5

// bytes per operand, used by the lane merge.
`define SU_LANES (`SU_DATA_W / 8)

`endif

// File: rtl/shift_unit_pkg.sv
`include "shift_unit_config.svh"

package shift_unit_pkg;

  // code 3 is unused and behaves as a left shift.
  typedef enum logic [1:0] {
    op_shl = 2'd0,
    op_shr = 2'd1,
    op_sar = 2'd2
  } shift_op_e;

  // shift view of the control word.
  typedef struct packed {
    logic [18:0]          rsvd_hi;
    logic                 dir_force;
    logic [3:0]           rsvd_mid;
    logic                 sign_fill;
    logic                 rsvd_lo;
    logic [`SU_AMT_W-1:0] amount;
  } ctrl_shift_t;

  // merge view of the same word.
  typedef struct packed {
    logic [7:0]           rsvd_hi;
    logic [7:0]           lane_mask;
    logic [6:0]           rsvd_mid;
    logic                 merge_en;
    logic [7:0]           rsvd_lo;
  } ctrl_merge_t;

  typedef union packed {
    ctrl_shift_t shift;
    ctrl_merge_t merge;
  } ctrl_word_u;

  // bit positions in a COASZP flag word.
  localparam int flag_c = 5;
  localparam int flag_o = 4;
  localparam int flag_a = 3;
  localparam int flag_s = 2;
  localparam int flag_z = 1;
  localparam int flag_p = 0;

endpackage

// File: rtl/shift_unit_top.sv
`timescale 1ns/1ps
`include "shift_unit_config.svh"

module shift_unit_top
  import shift_unit_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_req,
  input  shift_op_e             in_op,
  input  logic                  in_wide,
  input  logic [`SU_COND_W-1:0] in_cond,
  input  logic [`SU_FLAG_W-1:0] in_flags,
  input  logic [`SU_DATA_W-1:0] in_a,
  input  ctrl_word_u            in_ctrl,
  output logic                  in_ack,
  output logic                  out_req,
  output logic [`SU_DATA_W-1:0] out_result,
  output logic [`SU_FLAG_W-1:0] out_flags,
  output logic                  out_skipped,
  input  logic                  out_ack
);

  logic                  iss_valid;
  shift_op_e             iss_op;
  logic                  iss_wide;
  logic [`SU_COND_W-1:0] iss_cond;
  logic [`SU_FLAG_W-1:0] iss_flags;
  logic [`SU_DATA_W-1:0] iss_a;
  ctrl_word_u            iss_ctrl;
  logic                  stage_ready;
  logic                  stg_valid;
  logic [`SU_DATA_W-1:0] stg_result;
  logic [`SU_FLAG_W-1:0] stg_flags;
  logic                  stg_skipped;
  logic                  ret_ready;

  shift_issue shift_issue_i (
    .clk, .reset, .in_req, .in_op, .in_wide, .in_cond, .in_flags, .in_a, .in_ctrl,
    .in_ack, .stage_ready, .iss_valid, .iss_op, .iss_wide, .iss_cond, .iss_flags,
    .iss_a, .iss_ctrl
  );

  // shift, merge and flags, one register stage.
  lane_merge_flags lane_merge_flags_i (
    .clk, .reset, .iss_valid, .iss_op, .iss_wide, .iss_cond, .iss_flags, .iss_a,
    .iss_ctrl, .stage_ready, .stg_valid, .stg_result, .stg_flags, .stg_skipped,
    .ret_ready
  );

  result_return result_return_i (
    .clk, .reset, .stg_valid, .stg_result, .stg_flags, .stg_skipped, .ret_ready,
    .out_req, .out_result, .out_flags, .out_skipped, .out_ack
  );

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module shift_unit_tb -f all.f -o vsim

./obj_dir/vsim | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
  exit 0
else
  exit 1
fi

// File: verification/shift_unit_checker.sv
`timescale 1ns/1ps
`include "shift_unit_config.svh"

module shift_unit_checker (
  input logic                  clk,
  input logic                  reset,
  input logic                  in_ack,
  input logic                  out_req,
  input logic [`SU_DATA_W-1:0] out_result,
  input logic [`SU_FLAG_W-1:0] out_flags,
  input logic                  out_skipped
);

  logic [70:0] exp_q[$];
  logic        out_req_q;
  logic        in_ack_q;
  logic [70:0] exp;
  logic        bad;
  int          seen;
  int          accepted;
  int          errors;
  int          test_errors;
  int          test_results;

  initial begin
    seen = 0;
    accepted = 0;
    errors = 0;
    test_errors = 0;
    test_results = 0;
  end

  task automatic expect_result(input logic [70:0] value);
    exp_q.push_back(value);
  endtask

  // compare each new return against the oldest expected entry.
  always @(posedge clk) begin
    out_req_q <= reset ? 1'b0 : out_req;
    in_ack_q  <= reset ? 1'b0 : in_ack;
    if (!reset && in_ack && !in_ack_q)
      accepted++;
    if (!reset && out_req && !out_req_q) begin
      seen++;
      test_results++;
      if (exp_q.size() == 0) begin
        $display("unexpected result at %0t with nothing outstanding", $time);
        errors++;
        test_errors++;
      end else begin
        exp = exp_q.pop_front();
        bad = 1'b0;
        if (out_result !== exp[63:0]) begin
          $display("FAIL %0t out_result got %h exp %h", $time, out_result, exp[63:0]);
          bad = 1'b1;
        end
        if (out_flags !== exp[69:64]) begin
          $display("FAIL %0t out_flags got %b exp %b", $time, out_flags, exp[69:64]);
          bad = 1'b1;
        end
        if (out_skipped !== exp[70]) begin
          $display("FAIL %0t out_skipped got %b exp %b", $time, out_skipped, exp[70]);
          bad = 1'b1;
        end
        if (bad) begin
          errors++;
          test_errors++;
        end
      end
    end
  end

  task automatic end_test(input string name);
    if (test_errors == 0)
      $display("test %s: ok, %0d results", name, test_results);
    else
      $display("test %s: %0d errors in %0d results", name, test_errors, test_results);
    test_errors = 0;
    test_results = 0;
  endtask

  task automatic report_counts(input int sent);
    if (accepted != sent || exp_q.size() != 0) begin
      $display("operation count mismatch, %0d sent, %0d accepted, %0d left", sent, accepted,
               exp_q.size());
      errors++;
    end
    $display("sent %0d, accepted %0d, returned %0d, errors %0d", sent, accepted, seen, errors);
  endtask

endmodule

// File: verification/shift_unit_tb.sv
`timescale 1ns/1ps
`include "shift_unit_config.svh"

module shift_unit_tb
  import shift_unit_pkg::*;
;

  localparam int n_ops = 160;

  logic                  clk;
  logic                  reset;
  logic                  in_req;
  shift_op_e             in_op;
  logic                  in_wide;
  logic [`SU_COND_W-1:0] in_cond;
  logic [`SU_FLAG_W-1:0] in_flags;
  logic [`SU_DATA_W-1:0] in_a;
  ctrl_word_u            in_ctrl;
  logic                  in_ack;
  logic                  out_req;
  logic [`SU_DATA_W-1:0] out_result;
  logic [`SU_FLAG_W-1:0] out_flags;
  logic                  out_skipped;
  logic                  out_ack;
  integer                seed;
  logic                  slow;
  int                    sent;

  shift_unit_top shift_unit_top_i (.*);

  shift_unit_checker shift_unit_checker_i (
    .clk, .reset, .in_ack, .out_req, .out_result, .out_flags, .out_skipped
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // expected {skipped, flags, result} by shifting one bit at a time.
  function automatic logic [70:0] ref_model(input logic [1:0] op, input logic wide,
      input logic [4:0] cond, input logic [5:0] flags, input logic [63:0] a,
      input logic [31:0] ctrl);
    logic [63:0] x;
    logic [63:0] merged;
    logic [63:0] res;
    logic [5:0]  fl;
    logic        carry;
    logic        sign;
    logic        hit;
    int          amt;
    int          w;
    case (cond[3:0])
      4'd0: hit = 1'b1;
      4'd1: hit = flags[flag_z];
      4'd2: hit = !flags[flag_z];
      4'd3: hit = flags[flag_c];
      4'd4: hit = !flags[flag_c];
      4'd5: hit = flags[flag_s];
      4'd6: hit = !flags[flag_s];
      4'd7: hit = flags[flag_p];
      default: hit = 1'b0;
    endcase
    if (cond[4] && !hit)
      return {1'b1, flags, a};
    amt = wide ? int'(ctrl[5:0]) : int'(ctrl[4:0]);
    w = wide ? 64 : 32;
    x = wide ? a : {32'b0, a[31:0]};
    carry = 1'b0;
    if (ctrl[12])
      op = 2'd1;
    for (int k = 0; k < amt; k++) begin
      case (op)
        2'd1: begin
          carry = x[0];
          x = x >> 1;
        end
        2'd2: begin
          carry = x[0];
          sign = x[w-1];
          x = x >> 1;
          x[w-1] = sign;
        end
        default: begin
          carry = x[w-1];
          x = x << 1;
          if (!wide)
            x[63:32] = 32'b0;
        end
      endcase
    end
    for (int i = 0; i < 8; i++)
      merged[i*8 +: 8] = (ctrl[8] && !ctrl[16+i]) ? a[i*8 +: 8] : x[i*8 +: 8];
    res = merged;
    if (!wide)
      res[63:32] = ctrl[7] ? {32{merged[31]}} : 32'b0;
    fl = {carry, 1'b0, 1'b0, wide ? res[63] : res[31],
          wide ? (res == 64'b0) : (res[31:0] == 32'b0), ~^res[7:0]};
    return {1'b0, fl, res};
  endfunction

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  // four-phase producer.
  task automatic send_op(input logic [1:0] op, input logic wide, input logic [4:0] cond,
      input logic [5:0] flags, input logic [63:0] a, input logic [31:0] ctrl);
    @(posedge clk);
    while (in_ack)
      @(posedge clk);
    shift_unit_checker_i.expect_result(ref_model(op, wide, cond, flags, a, ctrl));
    sent++;
    in_req   <= 1'b1;
    in_op    <= shift_op_e'(op);
    in_wide  <= wide;
    in_cond  <= cond;
    in_flags <= flags;
    in_a     <= a;
    in_ctrl  <= ctrl;
    @(posedge clk);
    while (!in_ack)
      @(posedge clk);
    in_req <= 1'b0;
  endtask

  task automatic finish_test(input string name);
    while (shift_unit_checker_i.seen < sent)
      @(posedge clk);
    shift_unit_checker_i.end_test(name);
  endtask

  // consumer with a random ack delay.
  initial begin
    forever begin
      @(posedge clk);
      if (out_req && !out_ack) begin
        if (slow ? (($random(seed) & 7) == 0) : (($random(seed) & 3) != 0))
          out_ack <= 1'b1;
      end else if (!out_req && out_ack) begin
        out_ack <= 1'b0;
      end
    end
  end

  initial begin
    #(n_ops * 40 * 40);
    $display("timeout: results still outstanding after %0t", $time);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    seed = 35923;
    slow = 1'b0;
    sent = 0;
    reset = 1'b1;
    in_req = 1'b0;
    in_op = op_shl;
    in_wide = 1'b0;
    in_cond = '0;
    in_flags = '0;
    in_a = '0;
    in_ctrl = '0;
    out_ack = 1'b0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    // every code sees amount 0 and amount 63.
    for (int i = 0; i < 48; i++)
      send_op(2'(i % 3), 1'b1, 5'd0, 6'd0, rand64(),
              {26'b0, i < 3 ? 6'd0 : i < 6 ? 6'd63 : 6'($random(seed))});
    finish_test("shift64");
    for (int i = 0; i < 24; i++)
      send_op(2'(i % 3), 1'b0, 5'd0, 6'd0, rand64(),
              {19'b0, i >= 12, 4'b0, i[0], 1'b0, 6'($random(seed))});
    finish_test("wide32_fill_force");
    for (int i = 0; i < 24; i++)
      send_op(2'($random(seed)), 1'b1, 5'd0, 6'd0, rand64(),
              {8'b0, 8'($random(seed)), 7'b0, i[0], 2'b0, 6'($random(seed))});
    finish_test("lane_merge");
    for (int i = 0; i < 32; i++)
      send_op(2'($random(seed)), 1'($random(seed)),
              {i < 16 ? 1'b1 : 1'($random(seed)), 4'(i)}, 6'($random(seed)), rand64(),
              {26'b0, 6'($random(seed))});
    finish_test("conditions");
    slow = 1'b1;
    for (int i = 0; i < 32; i++)
      send_op(2'($random(seed)), 1'($random(seed)), 5'($random(seed)),
              6'($random(seed)), rand64(), 32'($random(seed)));
    finish_test("back_to_back");
    repeat (4) @(posedge clk);
    shift_unit_checker_i.report_counts(sent);
    if (shift_unit_checker_i.errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule
